// File: rtl/mem_sys_pkg.sv
// Shared types and sizes for the memory subsystem
// Bus command and size encodings, error status codes
// Instruction cache geometry and memory tag count

package mem_sys_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////

    typedef logic [31:0] addr_t;        // Byte address
    typedef logic [31:0] fetch_word_t;  // One instruction
    typedef logic [63:0] mem_data_t;    // Bus word, also one cache line
    typedef logic [3:0]  mem_tag_t;     // Zero means no transaction

    //////////////////////////////////////////////////////////////////////
    // Encodings
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        BUS_NONE  = 2'h0,
        BUS_LOAD  = 2'h1,
        BUS_STORE = 2'h2
    } bus_cmd_e;

    typedef enum logic [1:0] {
        BYTE   = 2'h0,
        HALF   = 2'h1,
        WORD   = 2'h2,
        DOUBLE = 2'h3
    } mem_size_e;

    // Reported to the outside when the processor stops
    typedef enum logic [1:0] {
        NO_ERROR      = 2'h0,
        HALTED_ON_WFI = 2'h1,
        ILLEGAL_INST  = 2'h2
    } error_code_e;

    //////////////////////////////////////////////////////////////////////
    // Geometry
    //////////////////////////////////////////////////////////////////////

    localparam int ICACHE_LINES = 32;
    localparam int ICACHE_IDX_W = 5;
    localparam int ICACHE_TAG_W = 24;   // 32 - index - 3 offset bits
    localparam int NUM_MEM_TAGS = 15;   // Tags 1..15

endpackage

// File: rtl/mem_port_if.sv
// Memory port of one requester
// Command side driven by the requester, reply side by the arbiter

interface mem_port_if;
    import mem_sys_pkg::*;

    // Requester to arbiter
    bus_cmd_e  command;
    addr_t     addr;
    mem_data_t wdata;
    mem_size_e size;

    // Arbiter to requester
    mem_tag_t  response;    // Nonzero on accept
    mem_data_t rdata;
    mem_tag_t  rtag;
    logic      rvalid;      // Reply belongs to this port

    modport requester (
        output command, addr, wdata, size,
        input  response, rdata, rtag, rvalid
    );

    modport arbiter (
        input  command, addr, wdata, size,
        output response, rdata, rtag, rvalid
    );

endinterface

// File: rtl/icache.sv
// Direct-mapped instruction cache, 32 lines of 8 bytes
// Hit path is combinational, a miss fetches the whole line
// A flush drops any pending fill

module icache (
    input  logic                     clock,
    input  logic                     rst_n,
    input  mem_sys_pkg::addr_t       proc2icache_addr,
    input  logic                     commit_mis_pred,
    output mem_sys_pkg::fetch_word_t icache2proc_data,
    output logic                     icache2proc_valid,
    mem_port_if.requester            mem
);
    import mem_sys_pkg::*;

    typedef enum logic [1:0] {IC_IDLE, IC_REQ, IC_WAIT} ic_state_e;

    mem_data_t               line_data [ICACHE_LINES];
    logic [ICACHE_TAG_W-1:0] line_tag  [ICACHE_LINES];
    logic [ICACHE_LINES-1:0] line_valid;

    ic_state_e state;
    ic_state_e state_nxt;
    mem_tag_t  pend_tag;        // Tag of the fill in flight
    addr_t     miss_addr;       // Line-aligned miss address
    logic      fetch_en;        // Low in the reset cycle

    logic [ICACHE_IDX_W-1:0] fetch_idx;
    logic [ICACHE_IDX_W-1:0] pend_idx;
    logic [ICACHE_TAG_W-1:0] fetch_tag;
    logic [ICACHE_TAG_W-1:0] pend_line_tag;
    mem_data_t               hit_line;
    logic                    hit;
    logic                    miss;
    logic                    accepted;
    logic                    fill;

    assign fetch_idx     = proc2icache_addr[ICACHE_IDX_W+2:3];
    assign fetch_tag     = proc2icache_addr[31:ICACHE_IDX_W+3];
    assign pend_idx      = miss_addr[ICACHE_IDX_W+2:3];
    assign pend_line_tag = miss_addr[31:ICACHE_IDX_W+3];

    // Lookup
    assign hit      = line_valid[fetch_idx] && (line_tag[fetch_idx] == fetch_tag);
    assign hit_line = line_data[fetch_idx];

    assign icache2proc_valid = hit;
    assign icache2proc_data  = proc2icache_addr[2] ? hit_line[63:32] : hit_line[31:0];

    assign miss     = fetch_en && !hit;
    assign accepted = (mem.response != '0);
    assign fill     = (state == IC_WAIT) && mem.rvalid && (mem.rtag == pend_tag);

    // Bus request
    always_comb begin
        mem.command = BUS_NONE;
        mem.addr    = miss_addr;
        case (state)
            IC_IDLE: begin
                if (miss) begin
                    mem.command = BUS_LOAD;  // Same cycle as the miss
                    mem.addr    = {proc2icache_addr[31:3], 3'b000};
                end
            end
            IC_REQ:  mem.command = BUS_LOAD;
            default: mem.command = BUS_NONE;
        endcase
    end

    assign mem.wdata = '0;
    assign mem.size  = DOUBLE;

    always_comb begin
        state_nxt = state;
        case (state)
            IC_IDLE: if (miss) state_nxt = accepted ? IC_WAIT : IC_REQ;
            IC_REQ:  if (accepted) state_nxt = IC_WAIT;
            IC_WAIT: if (fill) state_nxt = IC_IDLE;
            default: state_nxt = IC_IDLE;
        endcase
        if (commit_mis_pred)
            state_nxt = IC_IDLE;   // Abandon the fill, its reply no longer matches
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state      <= IC_IDLE;
            line_valid <= '0;
            fetch_en   <= 1'b0;
        end else begin
            state    <= state_nxt;
            fetch_en <= 1'b1;
            if (fill)
                line_valid[pend_idx] <= 1'b1;
        end
    end

    // Line storage and miss bookkeeping
    always_ff @(posedge clock) begin
        if (state == IC_IDLE && miss)
            miss_addr <= {proc2icache_addr[31:3], 3'b000};
        if (accepted && state != IC_WAIT)
            pend_tag <= mem.response;
        if (fill) begin
            line_data[pend_idx] <= mem.rdata;
            line_tag[pend_idx]  <= pend_line_tag;
        end
    end

endmodule

// File: rtl/data_port.sv
// Uncached load/store port, one access in flight
// Registers the request, holds it on the bus until accepted,
// then waits for the load reply

module data_port (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   dreq_valid,
    input  logic                   dreq_store,
    input  mem_sys_pkg::addr_t     dreq_addr,
    input  mem_sys_pkg::mem_data_t dreq_wdata,
    input  mem_sys_pkg::mem_size_e dreq_size,
    output logic                   dreq_ready,
    output mem_sys_pkg::mem_data_t load_data,
    output logic                   load_valid,
    mem_port_if.requester          mem
);
    import mem_sys_pkg::*;

    typedef enum logic [1:0] {DP_IDLE, DP_ISSUE, DP_WAIT} dp_state_e;

    dp_state_e state;

    // Captured request
    logic      req_store;
    addr_t     req_addr;
    mem_data_t req_wdata;
    mem_size_e req_size;
    mem_tag_t  pend_tag;

    logic accepted;
    logic reply;

    assign dreq_ready = (state == DP_IDLE);
    assign accepted   = (state == DP_ISSUE) && (mem.response != '0);
    assign reply      = (state == DP_WAIT) && mem.rvalid && (mem.rtag == pend_tag);

    assign mem.command = (state == DP_ISSUE) ? (req_store ? BUS_STORE : BUS_LOAD) : BUS_NONE;
    assign mem.addr    = req_addr;
    assign mem.wdata   = req_wdata;
    assign mem.size    = req_size;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state      <= DP_IDLE;
            load_valid <= 1'b0;
        end else begin
            load_valid <= reply;   // One cycle after the reply
            case (state)
                DP_IDLE:  if (dreq_valid) state <= DP_ISSUE;
                DP_ISSUE: begin
                    if (accepted)
                        state <= req_store ? DP_IDLE : DP_WAIT;  // Stores end on accept
                end
                DP_WAIT:  if (reply) state <= DP_IDLE;
                default:  state <= DP_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (dreq_valid && dreq_ready) begin
            req_store <= dreq_store;
            req_addr  <= dreq_addr;
            req_wdata <= dreq_wdata;
            req_size  <= dreq_size;
        end
        if (accepted)
            pend_tag <= mem.response;
        if (reply)
            load_data <= mem.rdata;
    end

endmodule

// File: rtl/cache_arbiter.sv
// Two-requester memory bus arbiter, data port has priority
// Owner table maps each accepted load tag to its requester
// so that replies are steered to the right port

module cache_arbiter (
    input  logic                   clock,
    input  logic                   rst_n,
    mem_port_if.arbiter            i_mem,
    mem_port_if.arbiter            d_mem,
    input  mem_sys_pkg::mem_tag_t  mem2cache_response,
    input  mem_sys_pkg::mem_data_t mem2cache_data,
    input  mem_sys_pkg::mem_tag_t  mem2cache_tag,
    output mem_sys_pkg::bus_cmd_e  cache2mem_command,
    output mem_sys_pkg::addr_t     cache2mem_addr,
    output mem_sys_pkg::mem_data_t cache2mem_data,
    output mem_sys_pkg::mem_size_e cache2mem_size
);
    import mem_sys_pkg::*;

    logic d_sel;
    logic i_sel;

    logic [NUM_MEM_TAGS-1:0] owner_valid;
    logic [NUM_MEM_TAGS-1:0] owner_is_d;   // 1 for data port, 0 for icache

    mem_tag_t acc_idx;
    mem_tag_t rep_idx;
    logic     load_accept;
    logic     reply_hit;

    //////////////////////////////////////////////////////////////////////
    // Command path
    //////////////////////////////////////////////////////////////////////

    assign d_sel = (d_mem.command != BUS_NONE);
    assign i_sel = !d_sel && (i_mem.command != BUS_NONE);

    assign cache2mem_command = d_sel ? d_mem.command : i_mem.command;
    assign cache2mem_addr    = d_sel ? d_mem.addr    : i_mem.addr;
    assign cache2mem_data    = d_sel ? d_mem.wdata   : i_mem.wdata;
    assign cache2mem_size    = d_sel ? d_mem.size    : i_mem.size;  // Icache asks for full lines

    // Loser sees a zero response and retries
    assign d_mem.response = d_sel ? mem2cache_response : '0;
    assign i_mem.response = i_sel ? mem2cache_response : '0;

    //////////////////////////////////////////////////////////////////////
    // Reply routing
    //////////////////////////////////////////////////////////////////////

    assign acc_idx     = mem2cache_response - 4'd1;
    assign rep_idx     = mem2cache_tag - 4'd1;
    assign load_accept = (cache2mem_command == BUS_LOAD) && (mem2cache_response != '0);
    assign reply_hit   = (mem2cache_tag != '0) && owner_valid[rep_idx];

    assign d_mem.rvalid = reply_hit && owner_is_d[rep_idx];
    assign i_mem.rvalid = reply_hit && !owner_is_d[rep_idx];

    assign d_mem.rdata = mem2cache_data;
    assign i_mem.rdata = mem2cache_data;
    assign d_mem.rtag  = mem2cache_tag;
    assign i_mem.rtag  = mem2cache_tag;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            owner_valid <= '0;
        end else begin
            if (reply_hit)
                owner_valid[rep_idx] <= 1'b0;
            if (load_accept)
                owner_valid[acc_idx] <= 1'b1;  // A reused tag wins over the free
        end
    end

    always_ff @(posedge clock) begin
        if (load_accept)
            owner_is_d[acc_idx] <= d_sel;
    end

endmodule

// File: rtl/mem_sys_top.sv
// Memory side of the processor
// Icache and data port share the main memory bus through the arbiter
// Also decodes the processor error status

module mem_sys_top (
    input  logic                     clock,
    input  logic                     rst_n,

    // Fetch side
    input  mem_sys_pkg::addr_t       proc2icache_addr,
    input  logic                     commit_mis_pred,
    output mem_sys_pkg::fetch_word_t icache2proc_data,
    output logic                     icache2proc_valid,

    // Data side
    input  logic                     dreq_valid,
    input  logic                     dreq_store,
    input  mem_sys_pkg::addr_t       dreq_addr,
    input  mem_sys_pkg::mem_data_t   dreq_wdata,
    input  mem_sys_pkg::mem_size_e   dreq_size,
    output logic                     dreq_ready,
    output mem_sys_pkg::mem_data_t   load_data,
    output logic                     load_valid,

    // Main memory
    input  mem_sys_pkg::mem_tag_t    mem2cache_response,
    input  mem_sys_pkg::mem_data_t   mem2cache_data,
    input  mem_sys_pkg::mem_tag_t    mem2cache_tag,
    output mem_sys_pkg::bus_cmd_e    cache2mem_command,
    output mem_sys_pkg::addr_t       cache2mem_addr,
    output mem_sys_pkg::mem_data_t   cache2mem_data,
    output mem_sys_pkg::mem_size_e   cache2mem_size,

    // Status
    input  logic                     commit_halt,
    input  logic                     commit_illegal,
    output mem_sys_pkg::error_code_e processor_error_status
);
    import mem_sys_pkg::*;

    mem_port_if i_port ();
    mem_port_if d_port ();

    // Illegal beats halt
    assign processor_error_status = commit_illegal ? ILLEGAL_INST  :
                                    commit_halt    ? HALTED_ON_WFI :
                                                     NO_ERROR;

    //////////////////////////////////////////////////////////////////////
    // Requesters
    //////////////////////////////////////////////////////////////////////

    icache icache_0 (
        .clock             (clock),
        .rst_n             (rst_n),
        .proc2icache_addr  (proc2icache_addr),
        .commit_mis_pred   (commit_mis_pred),
        .icache2proc_data  (icache2proc_data),
        .icache2proc_valid (icache2proc_valid),
        .mem               (i_port)
    );

    data_port data_port_0 (
        .clock      (clock),
        .rst_n      (rst_n),
        .dreq_valid (dreq_valid),
        .dreq_store (dreq_store),
        .dreq_addr  (dreq_addr),
        .dreq_wdata (dreq_wdata),
        .dreq_size  (dreq_size),
        .dreq_ready (dreq_ready),
        .load_data  (load_data),
        .load_valid (load_valid),
        .mem        (d_port)
    );

    //////////////////////////////////////////////////////////////////////
    // Bus arbiter
    //////////////////////////////////////////////////////////////////////

    cache_arbiter cache_arbiter_0 (
        .clock              (clock),
        .rst_n              (rst_n),
        .i_mem              (i_port),
        .d_mem              (d_port),
        .mem2cache_response (mem2cache_response),
        .mem2cache_data     (mem2cache_data),
        .mem2cache_tag      (mem2cache_tag),
        .cache2mem_command  (cache2mem_command),
        .cache2mem_addr     (cache2mem_addr),
        .cache2mem_data     (cache2mem_data),
        .cache2mem_size     (cache2mem_size)
    );

endmodule

// File: verif/mem_sys_assert.sv
// Bus protocol assertions for the cache arbiter
// Reset command, replies only to the granted port, no open store tags

module mem_sys_assert (
    input logic                                 clock,
    input logic                                 rst_n,
    input mem_sys_pkg::bus_cmd_e                command,
    input mem_sys_pkg::mem_tag_t                response,
    input mem_sys_pkg::mem_tag_t                i_response,
    input logic                                 i_rvalid,
    input logic                                 d_rvalid,
    input mem_sys_pkg::mem_tag_t                rtag,
    input logic [mem_sys_pkg::NUM_MEM_TAGS-1:0] owner_valid
);
    timeunit 1ns;
    timeprecision 100ps;
    import mem_sys_pkg::*;

    logic [15:0] store_tags;    // Tags last accepted as stores
    logic [15:0] icache_tags;   // Tags last granted to the icache

    always @(posedge clock) begin
        if (!rst_n) begin
            store_tags  <= '0;
            icache_tags <= '0;
        end else if (command != BUS_NONE && response != '0) begin
            store_tags[response]  <= (command == BUS_STORE);
            icache_tags[response] <= (i_response != '0);
        end
    end

    reset_idle: assert property (@(posedge clock) (!rst_n && $past(!rst_n)) |-> command == BUS_NONE)
        else $error("bus command active during reset");

    // Exactly one port sees a reply, the one that was granted its tag
    one_owner: assert property (@(posedge clock) disable iff (!rst_n)
        (i_rvalid || d_rvalid) |-> (i_rvalid != d_rvalid) && (i_rvalid == icache_tags[rtag]))
        else $error("reply routed to the wrong port");

    // A store tag never holds an owner entry, so no reply can reach the icache
    no_store_reply: assert property (@(posedge clock) disable iff (!rst_n)
        (owner_valid & store_tags[NUM_MEM_TAGS:1]) == '0)
        else $error("store tag holds an owner entry");

endmodule

bind cache_arbiter mem_sys_assert arbiter_checks (
    .clock       (clock),
    .rst_n       (rst_n),
    .command     (cache2mem_command),
    .response    (mem2cache_response),
    .i_response  (i_mem.response),
    .i_rvalid    (i_mem.rvalid),
    .d_rvalid    (d_mem.rvalid),
    .rtag        (mem2cache_tag),
    .owner_valid (owner_valid)
);

// File: verif/tb_mem_sys.sv
// Testbench for the memory subsystem top level
// Clock, random-latency memory model, stimulus, reference and checker

module tb_mem_sys;
    timeunit 1ns;
    timeprecision 100ps;
    import mem_sys_pkg::*;

    logic        clock, rst_n;
    addr_t       proc2icache_addr;
    logic        commit_mis_pred, commit_halt, commit_illegal;
    fetch_word_t icache2proc_data;
    logic        icache2proc_valid;
    logic        dreq_valid, dreq_store, dreq_ready, load_valid;
    addr_t       dreq_addr, cache2mem_addr;
    mem_data_t   dreq_wdata, load_data, mem2cache_data, cache2mem_data;
    mem_size_e   dreq_size, cache2mem_size;
    mem_tag_t    mem2cache_response, mem2cache_tag;
    bus_cmd_e    cache2mem_command;
    error_code_e processor_error_status;

    logic [15:0] lfsr = 16'd26753;
    int          errors, checks, cycle;
    mem_data_t   mem_words [addr_t];   // Model contents
    mem_data_t   shadow [addr_t];      // Expected contents
    mem_data_t   exp_q [$];
    mem_tag_t    pend_tag [$];
    addr_t       pend_addr [$];
    int          pend_due [$];
    logic [15:0] busy;
    mem_tag_t    next_tag;

    mem_sys_top dut (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic mem_data_t pattern_word(input addr_t a);
        return {a ^ 32'h9e37_79b9, ~a};
    endfunction

    // Byte lanes of the 8-byte word selected by size and offset
    function automatic mem_data_t lane_merge(input mem_data_t old, input addr_t a,
                                             input mem_data_t wd, input mem_size_e sz);
        int bytes;
        int off;
        mem_data_t r;
        bytes = 1 << sz;
        off   = a[2:0] & ~(bytes - 1);
        r     = old;
        for (int b = 0; b < 8; b++)
            if (b >= off && b < off + bytes)
                r[8*b +: 8] = wd[8*b +: 8];
        return r;
    endfunction

    function automatic mem_data_t ref_word(input addr_t a);
        addr_t al;
        al = {a[31:3], 3'b000};
        return shadow.exists(al) ? shadow[al] : pattern_word(al);
    endfunction

    function automatic error_code_e err_ref(input logic halt, input logic illegal);
        if (illegal)
            return ILLEGAL_INST;
        return halt ? HALTED_ON_WFI : NO_ERROR;
    endfunction

    // Counts one check, reports a mismatch in hex
    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[ERROR] %s got %0h expected %0h", name, got, exp);
        end
    endtask

    task automatic abort_run(input string why);
        $display("Timeout: %s", why);
        $display("Checks: %0d, errors: %0d", checks, errors + 1);
        $display("Test failed");
        $finish;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Memory model
    //////////////////////////////////////////////////////////////////////

    always @(posedge clock) begin
        addr_t al;
        cycle++;
        if (mem2cache_tag != '0)
            busy[mem2cache_tag] = 1'b0;
        if (rst_n && cache2mem_command != BUS_NONE && mem2cache_response != '0) begin
            al = {cache2mem_addr[31:3], 3'b000};
            if (cache2mem_command == BUS_STORE) begin
                mem_words[al] = lane_merge(mem_words.exists(al) ? mem_words[al]
                                           : pattern_word(al), cache2mem_addr,
                                           cache2mem_data, cache2mem_size);
            end else begin
                busy[mem2cache_response] = 1'b1;
                pend_tag.push_back(mem2cache_response);
                pend_addr.push_back(al);
                pend_due.push_back(cycle + lfsr_bits(3) + 1);   // 1 to 8 cycles
            end
        end
    end

    always @(negedge clock) begin
        mem2cache_tag      = '0;
        mem2cache_data     = '0;
        mem2cache_response = '0;
        foreach (pend_due[i]) begin
            if (pend_due[i] <= cycle) begin
                mem2cache_tag  = pend_tag[i];
                mem2cache_data = mem_words.exists(pend_addr[i]) ? mem_words[pend_addr[i]]
                                                                : pattern_word(pend_addr[i]);
                pend_tag.delete(i);
                pend_addr.delete(i);
                pend_due.delete(i);
                break;
            end
        end
        if (lfsr_bits(1)) begin
            for (int n = 0; n < 15; n++) begin
                next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
                if (!busy[next_tag]) begin
                    mem2cache_response = next_tag;
                    break;
                end
            end
        end
    end

    // Load checker
    always @(posedge clock) begin
        if (rst_n && load_valid) begin
            if (exp_q.size() == 0) begin
                checks++;
                errors++;
                $display("Load returned with no load outstanding");
            end else begin
                compare_value("load_data", load_data, exp_q.pop_front());
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus tasks
    //////////////////////////////////////////////////////////////////////

    task automatic fetch_check(input addr_t a);
        fetch_word_t exp;
        int n;
        @(negedge clock);
        proc2icache_addr = a;
        n = 0;
        do begin
            @(posedge clock);
            n++;
            if (n > 300)
                abort_run("fetch never became valid");
        end while (!icache2proc_valid);
        exp = a[2] ? ref_word(a) >> 32 : ref_word(a);
        compare_value("icache2proc_data", icache2proc_data, exp);
        // The filled line still hits a cycle later, with no bus request
        @(posedge clock);
        compare_value("icache2proc_valid", icache2proc_valid, 1'b1);
        compare_value("icache2proc_data", icache2proc_data, exp);
        checks++;
        assert (dut.i_port.command == BUS_NONE) else begin
            errors++;
            $display("Icache issued a bus command on a hit");
        end
    endtask

    task automatic data_request(input logic st, input addr_t a, input mem_data_t wd,
                                input mem_size_e sz);
        int n;
        n = 0;
        @(negedge clock);
        while (!dreq_ready) begin
            @(negedge clock);
            n++;
            if (n > 300)
                abort_run("data port never became ready");
        end
        dreq_valid = 1'b1;
        dreq_store = st;
        dreq_addr  = a;
        dreq_wdata = wd;
        dreq_size  = sz;
        if (st)
            shadow[{a[31:3], 3'b000}] = lane_merge(ref_word(a), a, wd, sz);
        else
            exp_q.push_back(ref_word(a));
        @(negedge clock);
        dreq_valid = 1'b0;
    endtask

    task automatic wait_load_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 || !dreq_ready) begin
            @(negedge clock);
            n++;
            if (n > 300)
                abort_run("outstanding loads never returned");
        end
    endtask

    initial begin
        addr_t a;
        rst_n = 1'b0;
        proc2icache_addr = 32'h1000_0000;
        {commit_mis_pred, commit_halt, commit_illegal} = '0;
        {dreq_valid, dreq_store} = '0;
        dreq_addr = '0;
        dreq_wdata = '0;
        dreq_size = DOUBLE;
        {mem2cache_response, mem2cache_tag, mem2cache_data} = '0;
        busy = '0;
        next_tag = '0;
        repeat (5) @(posedge clock);
        compare_value("cache2mem_command", cache2mem_command, BUS_NONE);
        compare_value("icache2proc_valid", icache2proc_valid, 1'b0);
        compare_value("load_valid", load_valid, 1'b0);
        compare_value("dreq_ready", dreq_ready, 1'b1);
        compare_value("processor_error_status", processor_error_status, NO_ERROR);
        @(negedge clock);
        rst_n = 1'b1;

        fetch_check(32'h1000_0004);
        fetch_check(32'h1000_0000);

        // Each store size, then a doubleword load
        for (int s = 0; s < 4; s++) begin
            a = 32'h2000_0000 + 8 * s + lfsr_bits(3);
            data_request(1'b1, a, {lfsr_bits(32), lfsr_bits(32)}, mem_size_e'(s));
            data_request(1'b0, a, '0, DOUBLE);
        end
        data_request(1'b0, 32'h2000_0100, '0, DOUBLE);
        wait_load_drain();

        // Fetch misses racing data accesses
        fork
            for (int i = 0; i < 8; i++)
                fetch_check(32'h1000_0000 | (lfsr_bits(12) << 3) | (lfsr_bits(1) << 2));
            for (int i = 0; i < 8; i++) begin
                a = 32'h2000_0200 + (lfsr_bits(6) << 3);
                data_request(1'b1, a, {lfsr_bits(32), lfsr_bits(32)},
                             mem_size_e'(lfsr_bits(2)));
                data_request(1'b0, a, '0, DOUBLE);
            end
        join
        wait_load_drain();

        // Flush during a pending fill
        @(negedge clock);
        proc2icache_addr = 32'h1000_8000;
        @(negedge clock);
        commit_mis_pred  = 1'b1;
        proc2icache_addr = 32'h1000_9008;
        @(negedge clock);
        commit_mis_pred = 1'b0;
        fetch_check(32'h1000_900c);

        for (int c = 0; c < 4; c++) begin
            @(negedge clock);
            {commit_illegal, commit_halt} = c[1:0];
            @(posedge clock);
            compare_value("processor_error_status", processor_error_status,
                          err_ref(commit_halt, commit_illegal));
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: sources.f
rtl/mem_sys_pkg.sv
rtl/mem_port_if.sv
rtl/icache.sv
rtl/data_port.sv
rtl/cache_arbiter.sv
rtl/mem_sys_top.sv
verif/mem_sys_assert.sv
verif/tb_mem_sys.sv

// File: Bender.yml
package:
  name: mem_sys

sources:
  - rtl/mem_sys_pkg.sv
  - rtl/mem_port_if.sv
  - rtl/icache.sv
  - rtl/data_port.sv
  - rtl/cache_arbiter.sv
  - rtl/mem_sys_top.sv
  - target: test
    files:
      - verif/mem_sys_assert.sv
      - verif/tb_mem_sys.sv
